/* mipsPkg.sv */
package mipsPkg;

        // Datapath and memory sizes
        localparam int dataW    = 32;
        localparam int regAddrW = 5;
        localparam int memAddrW = 8;
        localparam int memWords = 1 << memAddrW;
        localparam logic [dataW-1:0] resetPc = '0;

        // Primary opcodes of the supported subset
        typedef enum logic [5:0] {
                opRType = 6'h00,
                opBeq   = 6'h04,
                opBne   = 6'h05,
                opAddiu = 6'h09,
                opAndi  = 6'h0c,
                opOri   = 6'h0d,
                opLui   = 6'h0f,
                opLw    = 6'h23,
                opSw    = 6'h2b
        } opcodeT;

        // Funct field under opRType
        localparam logic [5:0] fnSll  = 6'h00;
        localparam logic [5:0] fnSrl  = 6'h02;
        localparam logic [5:0] fnAddu = 6'h21;
        localparam logic [5:0] fnSubu = 6'h23;
        localparam logic [5:0] fnAnd  = 6'h24;
        localparam logic [5:0] fnOr   = 6'h25;
        localparam logic [5:0] fnSlt  = 6'h2a;

        typedef enum logic [3:0] {
                aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluSrl, aluLui
        } aluOpT;

        //////////////////////////////
        // Pipeline payloads

        typedef struct packed {
                logic  regWrite;
                logic  memRead;
                logic  memWrite;
                logic  memToReg;
                logic  aluSrc;
                logic  branch;
                logic  branchNe;
                aluOpT aluOp;
        } ctrlT;

        // Destination already resolved from rt/rd in decode
        typedef struct packed {
                ctrlT                ctrl;
                logic [dataW-1:0]    pc;
                logic [dataW-1:0]    data1;
                logic [dataW-1:0]    data2;
                logic [dataW-1:0]    imm;
                logic [4:0]          shamt;
                logic [regAddrW-1:0] dest;
        } idExT;

        typedef struct packed {
                logic                regWrite;
                logic                memRead;
                logic                memWrite;
                logic [dataW-1:0]    result;
                logic [dataW-1:0]    storeData;
                logic [regAddrW-1:0] dest;
        } exMemT;

        typedef struct packed {
                logic                en;
                logic [regAddrW-1:0] dest;
                logic [dataW-1:0]    data;
        } wbT;

endpackage

/* memBusIf.sv */
`timescale 1ns/1ns

interface memBusIf;
        import mipsPkg::*;

        // Request, held by the master until accepted
        logic                reqValid;
        logic                reqReady;
        logic [memAddrW-1:0] addr;
        logic                we;
        logic [dataW-1:0]    wdata;
        // Read data, one cycle after acceptance
        logic                rspValid;
        logic [dataW-1:0]    rdata;

        modport master (
                output reqValid, addr, we, wdata,
                input  reqReady, rspValid, rdata
        );
        modport memory (
                input  reqValid, addr, we, wdata,
                output reqReady, rspValid, rdata
        );
endinterface

/* pipeReg.sv */
`timescale 1ns/1ns

module pipeReg #(
        parameter type payloadT = logic
) (
        input  logic    clk,
        input  logic    rstN,
        input  logic    flush,
        input  logic    inValid,
        output logic    inReady,
        input  payloadT inData,
        output logic    outValid,
        input  logic    outReady,
        output payloadT outData
);

        // Room when empty or draining this cycle
        assign inReady = !outValid || outReady;

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        outValid <= 1'b0;
                end else if (flush) begin
                        outValid <= 1'b0;
                end else if (inReady) begin
                        outValid <= inValid;
                end
        end

        // Payload only moves on a transfer, held otherwise
        always_ff @(posedge clk) begin
                if (inValid && inReady) begin
                        outData <= inData;
                end
        end

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ns

module fetchUnit (
        input  logic                      clk,
        input  logic                      rstN,
        memBusIf.master                   bus,
        input  logic                      redirectValid,
        input  logic [mipsPkg::dataW-1:0] redirectPc,
        output logic                      instrValid,
        input  logic                      instrReady,
        output logic [mipsPkg::dataW-1:0] instr,
        output logic [mipsPkg::dataW-1:0] pc
);
        import mipsPkg::*;

        logic [dataW-1:0] pcQ;
        logic [dataW-1:0] reqPcQ;
        logic [dataW-1:0] bufPcQ;
        logic [dataW-1:0] instrQ;
        logic             epochQ;
        logic             reqEpochQ;
        logic             pendQ;
        logic             bufValidQ;
        logic             reqFire;
        logic             rspHit;

        // One read in flight, only into an empty buffer
        assign bus.reqValid = !pendQ && !bufValidQ;
        assign bus.addr     = pcQ[memAddrW+1:2];
        assign bus.we       = 1'b0;
        assign bus.wdata    = '0;
        assign reqFire      = bus.reqValid && bus.reqReady;

        // Response from an older epoch is dropped
        assign rspHit = bus.rspValid && pendQ && (reqEpochQ == epochQ);

        // Fresh response bypasses the buffer
        assign instrValid = bufValidQ || rspHit;
        assign instr      = bufValidQ ? instrQ : bus.rdata;
        assign pc         = bufValidQ ? bufPcQ : reqPcQ;

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        pcQ       <= resetPc;
                        epochQ    <= 1'b0;
                        pendQ     <= 1'b0;
                        bufValidQ <= 1'b0;
                end else begin
                        pendQ <= reqFire;
                        if (redirectValid) begin
                                // Redirect beats a same-cycle PC advance
                                pcQ       <= redirectPc;
                                epochQ    <= !epochQ;
                                bufValidQ <= 1'b0;
                        end else begin
                                if (reqFire) begin
                                        pcQ <= pcQ + 32'd4;
                                end
                                if (rspHit && !instrReady) begin
                                        bufValidQ <= 1'b1;
                                end else if (bufValidQ && instrReady) begin
                                        bufValidQ <= 1'b0;
                                end
                        end
                end
        end

        // Tag of the outstanding read, parked instruction
        always_ff @(posedge clk) begin
                if (reqFire) begin
                        reqPcQ    <= pcQ;
                        reqEpochQ <= epochQ;
                end
                if (rspHit && !instrReady) begin
                        instrQ <= bus.rdata;
                        bufPcQ <= reqPcQ;
                end
        end

endmodule

/* decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
        input  logic                      clk,
        input  logic                      rstN,
        input  logic                      instrValid,
        output logic                      instrReady,
        input  logic [mipsPkg::dataW-1:0] instr,
        input  logic [mipsPkg::dataW-1:0] pc,
        input  logic                      redirectValid,
        output logic                      issueValid,
        input  logic                      issueReady,
        output mipsPkg::idExT             issueData,
        input  mipsPkg::wbT               wb
);
        import mipsPkg::*;

        localparam int numRegs = 1 << regAddrW;

        logic [5:0]          opcode;
        logic [5:0]          funct;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] dest;
        logic                zeroExt;
        logic                stall;
        logic                issueFire;
        ctrlT                ctrl;
        logic [dataW-1:0]    regs [numRegs];
        logic [dataW-1:0]    rdData1;
        logic [dataW-1:0]    rdData2;
        logic [numRegs-1:0]  busyQ;
        logic [numRegs-1:0]  busyNow;
        logic [numRegs-1:0]  setMask;
        logic [numRegs-1:0]  clrMask;

        assign opcode = instr[31:26];
        assign rs     = instr[25:21];
        assign rt     = instr[20:16];
        assign rd     = instr[15:11];
        assign funct  = instr[5:0];

        //////////////////////////////
        // Control decode

        always_comb begin
                ctrl    = '0;
                zeroExt = 1'b0;
                case (opcode)
                        opRType: begin
                                ctrl.regWrite = 1'b1;
                                case (funct)
                                        fnAddu:  ctrl.aluOp = aluAdd;
                                        fnSubu:  ctrl.aluOp = aluSub;
                                        fnAnd:   ctrl.aluOp = aluAnd;
                                        fnOr:    ctrl.aluOp = aluOr;
                                        fnSlt:   ctrl.aluOp = aluSlt;
                                        fnSll:   ctrl.aluOp = aluSll;
                                        fnSrl:   ctrl.aluOp = aluSrl;
                                        default: ctrl.regWrite = 1'b0;
                                endcase
                        end
                        opAddiu, opAndi, opOri, opLui: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                zeroExt       = (opcode == opAndi) || (opcode == opOri);
                                if (opcode == opAndi) begin
                                        ctrl.aluOp = aluAnd;
                                end else if (opcode == opOri) begin
                                        ctrl.aluOp = aluOr;
                                end else if (opcode == opLui) begin
                                        ctrl.aluOp = aluLui;
                                end
                        end
                        opLw: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.memRead  = 1'b1;
                                ctrl.memToReg = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        opSw: begin
                                ctrl.memWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        opBeq, opBne: begin
                                ctrl.branch   = 1'b1;
                                ctrl.branchNe = (opcode == opBne);
                        end
                        // Unknown opcodes retire as bubbles
                        default: ctrl = '0;
                endcase
        end

        // rd for R-type, rt otherwise, zero when nothing is written
        assign dest = !ctrl.regWrite ? '0 : (opcode == opRType) ? rd : rt;

        //////////////////////////////
        // Register file

        // Read side sees a same-cycle writeback
        always_comb begin
                rdData1 = regs[rs];
                rdData2 = regs[rt];
                if (wb.en && wb.dest == rs) begin
                        rdData1 = wb.data;
                end
                if (wb.en && wb.dest == rt) begin
                        rdData2 = wb.data;
                end
                // Register 0 always reads zero
                if (rs == '0) begin
                        rdData1 = '0;
                end
                if (rt == '0) begin
                        rdData2 = '0;
                end
        end

        always_ff @(posedge clk) begin
                if (wb.en && wb.dest != '0) begin
                        regs[wb.dest] <= wb.data;
                end
        end

        //////////////////////////////
        // Scoreboard and issue

        always_comb begin
                setMask = '0;
                clrMask = '0;
                if (wb.en) begin
                        clrMask[wb.dest] = 1'b1;
                end
                if (issueFire && dest != '0) begin
                        setMask[dest] = 1'b1;
                end
        end

        // Writeback this cycle already frees its register
        assign busyNow = busyQ & ~clrMask;
        assign stall   = busyNow[rs] || busyNow[rt] || busyNow[dest];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        busyQ <= '0;
                end else begin
                        busyQ <= busyNow | setMask;
                end
        end

        // Nothing issues behind a resolving branch
        assign issueValid = instrValid && !stall && !redirectValid;
        assign instrReady = issueReady && !stall && !redirectValid;
        assign issueFire  = issueValid && issueReady;

        assign issueData.ctrl  = ctrl;
        assign issueData.pc    = pc;
        assign issueData.data1 = rdData1;
        assign issueData.data2 = rdData2;
        assign issueData.imm   = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
        assign issueData.shamt = instr[10:6];
        assign issueData.dest  = dest;

endmodule

/* executeStage.sv */
`timescale 1ns/1ns

module executeStage (
        input  logic                      inValid,
        output logic                      inReady,
        input  mipsPkg::idExT             inData,
        output logic                      outValid,
        input  logic                      outReady,
        output mipsPkg::exMemT            outData,
        output logic                      redirectValid,
        output logic [mipsPkg::dataW-1:0] redirectPc
);
        import mipsPkg::*;

        logic [dataW-1:0] opB;
        logic [dataW-1:0] result;
        logic             taken;

        // Second operand is the immediate for I-type and memory ops
        assign opB = inData.ctrl.aluSrc ? inData.imm : inData.data2;

        always_comb begin
                case (inData.ctrl.aluOp)
                        aluAdd:  result = inData.data1 + opB;
                        aluSub:  result = inData.data1 - opB;
                        aluAnd:  result = inData.data1 & opB;
                        aluOr:   result = inData.data1 | opB;
                        aluSlt:  result = dataW'($signed(inData.data1) < $signed(opB));
                        aluSll:  result = inData.data2 << inData.shamt;
                        aluSrl:  result = inData.data2 >> inData.shamt;
                        aluLui:  result = {inData.imm[15:0], 16'b0};
                        default: result = inData.data1 + opB;
                endcase
        end

        // beq on equal, bne on not equal
        assign taken = inData.ctrl.branch &&
                       ((inData.data1 == inData.data2) != inData.ctrl.branchNe);

        // Only as the branch moves on, so it fires once
        assign redirectValid = inValid && outReady && taken;
        assign redirectPc    = inData.pc + 32'd4 + {inData.imm[dataW-3:0], 2'b00};

        assign outValid = inValid;
        assign inReady  = outReady;

        // Branches carry regWrite low and retire silently
        assign outData.regWrite  = inData.ctrl.regWrite;
        assign outData.memRead   = inData.ctrl.memRead;
        assign outData.memWrite  = inData.ctrl.memWrite;
        assign outData.result    = result;
        assign outData.storeData = inData.data2;
        assign outData.dest      = inData.dest;

endmodule

/* memWriteback.sv */
`timescale 1ns/1ns

module memWriteback (
        input  logic           clk,
        input  logic           rstN,
        input  logic           inValid,
        output logic           inReady,
        input  mipsPkg::exMemT inData,
        memBusIf.master        bus,
        output mipsPkg::wbT    wb
);
        import mipsPkg::*;

        logic waitQ;

        // Request goes out once, then the load waits for data
        assign bus.reqValid = inValid && (inData.memRead || inData.memWrite) && !waitQ;
        assign bus.addr     = inData.result[memAddrW+1:2];
        assign bus.we       = inData.memWrite;
        assign bus.wdata    = inData.storeData;

        always_comb begin
                if (!inValid) begin
                        inReady = 1'b1;
                end else if (inData.memRead) begin
                        inReady = waitQ && bus.rspValid;
                end else if (inData.memWrite) begin
                        inReady = bus.reqReady;
                end else begin
                        inReady = 1'b1;
                end
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        waitQ <= 1'b0;
                end else if (bus.reqValid && bus.reqReady && !bus.we) begin
                        waitQ <= 1'b1;
                end else if (bus.rspValid) begin
                        waitQ <= 1'b0;
                end
        end

        // One write per retiring instruction
        assign wb.en   = inValid && inReady && inData.regWrite;
        assign wb.dest = inData.dest;
        assign wb.data = inData.memRead ? bus.rdata : inData.result;

endmodule

/* sharedMem.sv */
`timescale 1ns/1ns

module sharedMem (
        input  logic                         clk,
        input  logic                         rstN,
        memBusIf.memory                      instrBus,
        memBusIf.memory                      dataBus,
        output logic                         storeValid,
        output logic [mipsPkg::memAddrW-1:0] storeAddr,
        output logic [mipsPkg::dataW-1:0]    storeData
);
        import mipsPkg::*;

        logic [dataW-1:0]    mem [memWords];
        logic [dataW-1:0]    rdataQ;
        logic [memAddrW-1:0] selAddr;
        logic [dataW-1:0]    selWdata;
        logic                selWe;
        logic                anyReq;
        logic                instrRspQ;
        logic                dataRspQ;

        // Program image, rest of memory zero
        initial begin
                for (int i = 0; i < memWords; i++) begin
                        mem[i] = '0;
                end
                $readmemh("prog.hex", mem);
        end

        //////////////////////////////
        // Arbiter, data side first

        assign dataBus.reqReady  = 1'b1;
        assign instrBus.reqReady = !dataBus.reqValid;
        assign anyReq            = dataBus.reqValid || instrBus.reqValid;
        assign selAddr           = dataBus.reqValid ? dataBus.addr : instrBus.addr;
        assign selWdata          = dataBus.reqValid ? dataBus.wdata : instrBus.wdata;
        assign selWe             = dataBus.reqValid ? dataBus.we : instrBus.we;

        // Single port, one access per cycle
        always_ff @(posedge clk) begin
                if (anyReq && selWe) begin
                        mem[selAddr] <= selWdata;
                end else if (anyReq) begin
                        rdataQ <= mem[selAddr];
                end
                storeAddr <= selAddr;
                storeData <= selWdata;
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        instrRspQ  <= 1'b0;
                        dataRspQ   <= 1'b0;
                        storeValid <= 1'b0;
                end else begin
                        instrRspQ  <= instrBus.reqValid && !dataBus.reqValid && !instrBus.we;
                        dataRspQ   <= dataBus.reqValid && !dataBus.we;
                        storeValid <= anyReq && selWe;
                end
        end

        // Read data shared, response strobes per master
        assign instrBus.rspValid = instrRspQ;
        assign instrBus.rdata    = rdataQ;
        assign dataBus.rspValid  = dataRspQ;
        assign dataBus.rdata     = rdataQ;

endmodule

/* mipsCore.sv */
`timescale 1ns/1ns

module mipsCore (
        input  logic                         clk,
        input  logic                         rstN,
        output logic                         storeValid,
        output logic [mipsPkg::memAddrW-1:0] storeAddr,
        output logic [mipsPkg::dataW-1:0]    storeData
);
        import mipsPkg::*;

        memBusIf instrBus ();
        memBusIf dataBus ();

        // Fetch to decode
        logic             instrValid;
        logic             instrReady;
        logic [dataW-1:0] instr;
        logic [dataW-1:0] pc;
        // Branch redirect from execute
        logic             redirectValid;
        logic [dataW-1:0] redirectPc;
        // Stage hand-offs
        logic             issueValid;
        logic             issueReady;
        idExT             issueData;
        logic             exInValid;
        logic             exInReady;
        idExT             exInData;
        logic             exOutValid;
        logic             exOutReady;
        exMemT            exOutData;
        logic             mwValid;
        logic             mwReady;
        exMemT            mwData;
        wbT               wb;

        fetchUnit u_fetchUnit (
                .clk           (clk),
                .rstN          (rstN),
                .bus           (instrBus.master),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc),
                .instrValid    (instrValid),
                .instrReady    (instrReady),
                .instr         (instr),
                .pc            (pc)
        );

        decodeStage u_decodeStage (
                .clk           (clk),
                .rstN          (rstN),
                .instrValid    (instrValid),
                .instrReady    (instrReady),
                .instr         (instr),
                .pc            (pc),
                .redirectValid (redirectValid),
                .issueValid    (issueValid),
                .issueReady    (issueReady),
                .issueData     (issueData),
                .wb            (wb)
        );

        // Younger work never enters behind a branch, so no flush here
        pipeReg #(.payloadT(idExT)) idExReg (
                .clk      (clk),
                .rstN     (rstN),
                .flush    (1'b0),
                .inValid  (issueValid),
                .inReady  (issueReady),
                .inData   (issueData),
                .outValid (exInValid),
                .outReady (exInReady),
                .outData  (exInData)
        );

        executeStage u_executeStage (
                .inValid       (exInValid),
                .inReady       (exInReady),
                .inData        (exInData),
                .outValid      (exOutValid),
                .outReady      (exOutReady),
                .outData       (exOutData),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc)
        );

        pipeReg #(.payloadT(exMemT)) exMemReg (
                .clk      (clk),
                .rstN     (rstN),
                .flush    (1'b0),
                .inValid  (exOutValid),
                .inReady  (exOutReady),
                .inData   (exOutData),
                .outValid (mwValid),
                .outReady (mwReady),
                .outData  (mwData)
        );

        memWriteback u_memWriteback (
                .clk     (clk),
                .rstN    (rstN),
                .inValid (mwValid),
                .inReady (mwReady),
                .inData  (mwData),
                .bus     (dataBus.master),
                .wb      (wb)
        );

        sharedMem u_sharedMem (
                .clk        (clk),
                .rstN       (rstN),
                .instrBus   (instrBus.memory),
                .dataBus    (dataBus.memory),
                .storeValid (storeValid),
                .storeAddr  (storeAddr),
                .storeData  (storeData)
        );

endmodule

/* tbMipsCore.sv */
`timescale 1ns/1ns

module tbMipsCore;
        import mipsPkg::*;

        // Cycle budgets
        localparam int runTimeout   = 3000;
        localparam int quietCycles  = 60;
        // Store count at which the second reset hits
        localparam int midRunStores = 6;

        logic                clk = 1'b0;
        logic                rstN;
        logic                storeValid;
        logic [memAddrW-1:0] storeAddr;
        logic [dataW-1:0]    storeData;

        // Expected store trace in program order
        logic [memAddrW-1:0] expAddr [$];
        logic [dataW-1:0]    expData [$];
        string               expTest [$];

        int                  storeIdx;
        int                  errors;
        int                  checks;
        logic                timedOut;

        mipsCore u_mipsCore (
                .clk        (clk),
                .rstN       (rstN),
                .storeValid (storeValid),
                .storeAddr  (storeAddr),
                .storeData  (storeData)
        );

        initial begin
                forever #5 clk = ~clk;
        end

        //////////////////////////////
        // Expected stores

        task automatic addStore(input string name, input logic [memAddrW-1:0] addr,
                                input logic [dataW-1:0] data);
                expTest.push_back(name);
                expAddr.push_back(addr);
                expData.push_back(data);
        endtask

        // Data region starts at byte 0x100 which is word 0x40
        task automatic buildTable();
                logic [dataW-1:0] r1;
                logic [dataW-1:0] r2;
                logic [dataW-1:0] r9;
                logic [dataW-1:0] r15;
                r1  = 32'd5;
                r2  = 32'hffff_fffd;
                // addu and subu
                addStore("alu", 8'h40, r1 + r2);
                addStore("alu", 8'h41, r2 - r1);
                // slt ored with sll by 4
                addStore("alu", 8'h42, 32'd1 | (r1 << 4));
                // srl by 28 fills with zeros
                addStore("alu", 8'h43, r2 >> 28);
                // lui then ori with a zero-extended immediate
                r9 = {16'h1234, 16'h0000} | 32'h0000_abcd;
                addStore("alu", 8'h44, r9);
                // andi zero extended plus and with subu result
                addStore("alu", 8'h45, (r9 & 32'h0000_ff0f) + (r9 & (r2 - r1)));
                // Reload of the first store followed by a dependent add
                r15 = (r1 + r2) + r1;
                addStore("loadUse", 8'h46, r15);
                // Word 0 of the image is addiu $1, $0, 5
                addStore("loadUse", 8'h47, 32'h2401_0005 + r15);
                // Both taken shadows are skipped and the not-taken beq reaches this store
                addStore("branch", 8'h48, 32'd1);
                // Loop counts 4 down to 1 and stores upward from word 0x50
                for (int i = 0; i < 4; i++) begin
                        addStore("storeLoop", 8'h50 + 8'(i), 32'd4 - 32'(i));
                end
        endtask

        //////////////////////////////
        // Sequencing helpers

        task automatic holdReset();
                rstN = 1'b0;
                repeat (4) @(posedge clk);
                #1;
                rstN = 1'b1;
        endtask

        task automatic waitForStores(input int target, input int limit);
                int cycles;
                cycles = 0;
                while (storeIdx < target && cycles < limit) begin
                        @(posedge clk);
                        cycles++;
                end
                if (storeIdx < target) begin
                        $display("Timeout: waited %0d cycles for store %0d, saw only %0d",
                                 limit, target, storeIdx);
                        errors++;
                        timedOut = 1'b1;
                end
        endtask

        //////////////////////////////
        // Store trace checker

        // Sampled on the falling edge away from DUT updates
        always @(negedge clk) begin
                if (!rstN) begin
                        // Trace restarts from entry 0 after any reset
                        storeIdx = 0;
                        checks++;
                        assert (!storeValid) else begin
                                $display("storeValid was high while reset was asserted");
                                errors++;
                        end
                end else if (storeValid) begin
                        checks++;
                        assert (storeIdx < expData.size()) else begin
                                $display("Unexpected extra store to %h with data %h",
                                         storeAddr, storeData);
                                errors++;
                        end
                        if (storeIdx < expData.size()) begin
                                assert (storeAddr == expAddr[storeIdx] &&
                                        storeData == expData[storeIdx]) else begin
                                        $display("ERR %s store %0d expected %h:%h actual %h:%h",
                                                 expTest[storeIdx], storeIdx,
                                                 expAddr[storeIdx], expData[storeIdx],
                                                 storeAddr, storeData);
                                        errors++;
                                end
                        end
                        storeIdx++;
                end
        end

        //////////////////////////////
        // Main sequence

        initial begin
                rstN     = 1'b0;
                storeIdx = 0;
                errors   = 0;
                checks   = 0;
                timedOut = 1'b0;
                buildTable();
                holdReset();
                // First pass is cut short partway through
                waitForStores(midRunStores, runTimeout);
                if (!timedOut) begin
                        @(posedge clk);
                        #1;
                        holdReset();
                        // Whole program again from its first store
                        waitForStores(expData.size(), runTimeout);
                end
                if (!timedOut) begin
                        // Core parks in its self loop and must store nothing more
                        repeat (quietCycles) @(posedge clk);
                end
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("TESTS PASSED");
                end else begin
                        $display("TESTS FAILED");
                end
                $finish;
        end

endmodule

/* prog.hex */
// One 32-bit instruction word per line, loaded from word address 0
// Trailing comments give the byte address and the assembly
24010005  // 00 addiu $1, $0, 5
2402FFFD  // 04 addiu $2, $0, -3
240A0100  // 08 addiu $10, $0, 0x100
00221821  // 0c addu  $3, $1, $2
AD430000  // 10 sw    $3, 0($10)
00412023  // 14 subu  $4, $2, $1
AD440004  // 18 sw    $4, 4($10)
0041282A  // 1c slt   $5, $2, $1
00013100  // 20 sll   $6, $1, 4
00A63825  // 24 or    $7, $5, $6
AD470008  // 28 sw    $7, 8($10)
00024702  // 2c srl   $8, $2, 28
AD48000C  // 30 sw    $8, 12($10)
3C091234  // 34 lui   $9, 0x1234
3529ABCD  // 38 ori   $9, $9, 0xabcd
AD490010  // 3c sw    $9, 16($10)
312BFF0F  // 40 andi  $11, $9, 0xff0f
01246024  // 44 and   $12, $9, $4
016C6821  // 48 addu  $13, $11, $12
AD4D0014  // 4c sw    $13, 20($10)
8D4E0000  // 50 lw    $14, 0($10)
01C17821  // 54 addu  $15, $14, $1
AD4F0018  // 58 sw    $15, 24($10)
8C100000  // 5c lw    $16, 0($0)
020F8821  // 60 addu  $17, $16, $15
AD51001C  // 64 sw    $17, 28($10)
10210001  // 68 beq   $1, $1, +1  taken
AD42003C  // 6c sw    $2, 60($10) shadow
14220001  // 70 bne   $1, $2, +1  taken
AD42003C  // 74 sw    $2, 60($10) shadow
10220001  // 78 beq   $1, $2, +1  not taken
AD450020  // 7c sw    $5, 32($10)
24120004  // 80 addiu $18, $0, 4
25530040  // 84 addiu $19, $10, 0x40
AE720000  // 88 sw    $18, 0($19)
26730004  // 8c addiu $19, $19, 4
2652FFFF  // 90 addiu $18, $18, -1
1640FFFC  // 94 bne   $18, $0, 0x88
1000FFFF  // 98 beq   $0, $0, 0x98

/* verilog.f */
mipsPkg.sv
memBusIf.sv
pipeReg.sv
fetchUnit.sv
decodeStage.sv
executeStage.sv
memWriteback.sv
sharedMem.sv
mipsCore.sv
tbMipsCore.sv
